// ==== files.f ====
verilog/imuldiv_pkg.sv
verilog/muldiv_req_if.sv
verilog/muldiv_steer.sv
verilog/int_mul_iterative.sv
verilog/int_div_ctrl.sv
verilog/int_div_dpath.sv
verilog/imuldiv_unit.sv
verification/imuldiv_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the imuldiv testbench with Verilator, status 1 unless the pass line shows up
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module imuldiv_tb -Mdir obj_dir -f files.f || exit 1
out="$(./obj_dir/Vimuldiv_tb)"
echo "$out"
echo "$out" | grep -qx "Test passed" && exit 0 || exit 1

// ==== verification/imuldiv_vectors.txt ====
// columns: op a b hi lo, all hex
// op 0 = mul, 1 = mulu, 2 = div, 3 = divu
// mul: hi/lo = upper/lower product word, div: hi = remainder, lo = quotient
// mul and div alternate so each response must come from the other engine
00000000 00000007 fffffffd ffffffff ffffffeb
00000002 ffffffec 00000003 fffffffe fffffffa
00000001 ffffffff ffffffff fffffffe 00000001
00000003 ffffffec 00000003 00000002 5555554e
00000000 ffffffff ffffffff 00000000 00000001
00000002 00000014 fffffffd 00000002 fffffffa
00000001 80000000 00000002 00000001 00000000
00000002 ffffffec fffffffd fffffffe 00000006
00000000 80000000 80000000 40000000 00000000
00000002 80000000 ffffffff 00000000 80000000
00000000 12345678 fffffff0 fffffffe dcba9880
00000003 00000064 00000000 00000064 ffffffff
00000001 fffffffe 00000003 00000002 fffffffa
00000002 fffffff9 00000000 fffffff9 ffffffff
00000000 00000000 87654321 00000000 00000000
00000003 80000000 ffffffff 80000000 00000000
00000001 00010000 00010000 00000001 00000000
00000002 00000007 00000002 00000001 00000003
00000000 fffffffe 00000005 ffffffff fffffff6
00000003 12345678 00000010 00000008 01234567

// ==== verification/imuldiv_tb.sv ====
// testbench for imuldiv_unit with vectors from verification/imuldiv_vectors.txt
// run from the project root and expects N_ITER = 32 inside the unit

`timescale 1ns/1ns

module imuldiv_tb;

  localparam int N_ITER  = 32;
  localparam int MAX_VEC = 64;

  logic                        clk;
  logic                        reset;
  imuldiv_pkg::muldiv_op_e     req_op;
  logic [31:0]                 req_a;
  logic [31:0]                 req_b;
  logic                        req_val;
  logic                        req_rdy;
  imuldiv_pkg::muldiv_result_t resp_result;
  logic                        resp_val;
  logic                        resp_rdy;

  // each vector takes five words in the order op a b then expected hi and lo
  logic [31:0] vec_mem [0:5*MAX_VEC-1];
  int          n_vec;
  int          cycles;
  int          cycle_limit;
  int          pass_cnt;
  int          fail_cnt;
  int          test_err;
  int          other_err;
  logic [31:0] lfsr;

  imuldiv_unit dut (
    .clk         (clk),
    .reset       (reset),
    .req_op      (req_op),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // rising edges since time zero
  always @(posedge clk) cycles <= cycles + 1;

  // --------------------
  // helpers
  // --------------------

  // galois step as a right shift with feedback mask
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) return (s >> 1) ^ 32'h80200003;
    return s >> 1;
  endfunction

  // one lfsr step per bit taken
  task automatic draw_bits(input int n, output int v);
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = (v << 1) | int'(lfsr[0]);
    end
  endtask

  task automatic check_product(input int idx, input imuldiv_pkg::muldiv_result_t got,
                               input logic [63:0] exp);
    if ({got.hi, got.lo} !== exp) begin
      $display("MISMATCH at %0t: test %0d product %h, expected %h",
               $time, idx, {got.hi, got.lo}, exp);
      test_err++;
    end else begin
      $display("test %0d: product %h ok", idx, {got.hi, got.lo});
    end
  endtask

  task automatic check_divrem(input int idx, input imuldiv_pkg::muldiv_result_t got,
                              input logic [31:0] exp_rem, input logic [31:0] exp_quo);
    if (got.hi !== exp_rem || got.lo !== exp_quo) begin
      $display("MISMATCH at %0t: test %0d rem %h quo %h, expected rem %h quo %h",
               $time, idx, got.hi, got.lo, exp_rem, exp_quo);
      test_err++;
    end else begin
      $display("test %0d: rem %h quo %h ok", idx, got.hi, got.lo);
    end
  endtask

  // response must sit still while it waits for resp_rdy
  task automatic check_hold(input int idx, input imuldiv_pkg::muldiv_result_t held);
    if (!resp_val) begin
      $display("test %0d: resp_val dropped before the response was taken", idx);
      test_err++;
    end
    if (resp_result !== held) begin
      $display("MISMATCH at %0t: test %0d result moved to %h while stalled, was %h",
               $time, idx, resp_result, held);
      test_err++;
    end
    if (req_rdy) begin
      $display("test %0d: req_rdy high while a response is pending", idx);
      test_err++;
    end
  endtask

  // called just after a rising edge
  task automatic send_request(input int idx);
    req_op  = imuldiv_pkg::muldiv_op_e'(vec_mem[5*idx][1:0]);
    req_a   = vec_mem[5*idx+1];
    req_b   = vec_mem[5*idx+2];
    req_val = 1'b1;
  endtask

  // --------------------
  // one operation entered at a falling edge with its request on the bus
  // --------------------

  task automatic run_vector(input int idx);
    logic [31:0]                 op_w;
    int                          xfer_cyc;
    int                          lat;
    int                          stall;
    imuldiv_pkg::muldiv_result_t held;
    op_w     = vec_mem[5*idx];
    test_err = 0;
    while (!req_rdy) begin
      @(posedge clk);
      @(negedge clk);
    end
    // next edge takes the request
    xfer_cyc = cycles + 1;
    @(posedge clk);
    #1 req_val = 1'b0;
    @(negedge clk);
    while (!resp_val) begin
      if (req_rdy) begin
        $display("test %0d: req_rdy high while an operation is in flight", idx);
        test_err++;
      end
      @(posedge clk);
      @(negedge clk);
    end
    // transfer edge counts as the first of N_ITER + 1
    lat = cycles - xfer_cyc;
    if (lat != N_ITER) begin
      $display("test %0d: response came %0d edges after the request, expected %0d",
               idx, lat, N_ITER);
      test_err++;
    end
    held = resp_result;
    draw_bits(2, stall);
    repeat (stall) begin
      @(posedge clk);
      @(negedge clk);
      check_hold(idx, held);
    end
    @(posedge clk);
    #1 resp_rdy = 1'b1;
    @(negedge clk);
    check_hold(idx, held);
    @(posedge clk);
    #1 resp_rdy = 1'b0;
    // following request goes out on the same cycle the unit frees up
    if (idx + 1 < n_vec) send_request(idx + 1);
    @(negedge clk);
    if (resp_val) begin
      $display("test %0d: response still valid after it was taken", idx);
      test_err++;
    end
    if (!req_rdy) begin
      $display("test %0d: req_rdy low after the response was taken", idx);
      test_err++;
    end
    // op bit 1 marks a divide
    if (op_w[1]) check_divrem(idx, held, vec_mem[5*idx+3], vec_mem[5*idx+4]);
    else check_product(idx, held, {vec_mem[5*idx+3], vec_mem[5*idx+4]});
    if (test_err == 0) pass_cnt++;
    else fail_cnt++;
  endtask

  // --------------------
  // watchdog
  // --------------------

  initial begin
    wait (cycle_limit > 0);
    while (cycles < cycle_limit) @(negedge clk);
    $display("timeout: the unit stopped responding, %0d cycles elapsed", cycles);
    $display("Test failed");
    $finish;
  end

  // --------------------
  // main sequence
  // --------------------

  initial begin
    reset    = 1'b1;
    req_op   = imuldiv_pkg::OP_MUL;
    req_a    = '0;
    req_b    = '0;
    req_val  = 1'b0;
    resp_rdy = 1'b0;
    lfsr     = 32'he241031e;
    // unused slots get an opcode word above 3 that ends the list
    for (int i = 0; i < 5*MAX_VEC; i++) vec_mem[i] = 32'hbad00000 | 32'(i);
    $readmemh("verification/imuldiv_vectors.txt", vec_mem);
    n_vec = 0;
    while (n_vec < MAX_VEC && vec_mem[5*n_vec] <= 32'd3) n_vec++;
    cycle_limit = n_vec * (N_ITER + 8) + 100;
    repeat (16) @(posedge clk);
    #1 reset = 1'b0;
    @(negedge clk);
    if (!req_rdy || resp_val) begin
      $display("after reset: req_rdy=%b resp_val=%b, expected 1 and 0", req_rdy, resp_val);
      other_err++;
    end
    if (n_vec == 0) begin
      $display("no test vectors were read");
      other_err++;
    end
    @(posedge clk);
    #1;
    if (n_vec > 0) send_request(0);
    @(negedge clk);
    for (int i = 0; i < n_vec; i++) run_vector(i);
    $display("%0d tests passed, %0d failed, %0d other errors", pass_cnt, fail_cnt, other_err);
    if (n_vec > 0 && fail_cnt == 0 && other_err == 0) $display("Test passed");
    else $display("Test failed");
    $finish;
  end

endmodule

// ==== verilog/imuldiv_unit.sv ====
// iterative multiply/divide unit, one operation in flight
// response valid N_ITER+1 edges after the request transfer, held until taken

`timescale 1ns/1ns

module imuldiv_unit (
  input  logic                        clk,
  input  logic                        reset,
  input  imuldiv_pkg::muldiv_op_e     req_op,
  input  logic [31:0]                 req_a,
  input  logic [31:0]                 req_b,
  input  logic                        req_val,
  output logic                        req_rdy,
  output imuldiv_pkg::muldiv_result_t resp_result,
  output logic                        resp_val,
  input  logic                        resp_rdy
);

  localparam int N_ITER = 32;

  // per-engine request bundles
  muldiv_req_if mul_req_if ();
  muldiv_req_if div_req_if ();

  imuldiv_pkg::muldiv_result_t mul_result;
  imuldiv_pkg::muldiv_result_t div_result;
  logic mul_resp_val;
  logic mul_resp_rdy;
  logic div_resp_val;
  logic div_resp_rdy;
  logic div_load_en;
  logic div_step_en;

  muldiv_steer steer (
    .clk          (clk),
    .reset        (reset),
    .req_op       (req_op),
    .req_a        (req_a),
    .req_b        (req_b),
    .req_val      (req_val),
    .req_rdy      (req_rdy),
    .resp_result  (resp_result),
    .resp_val     (resp_val),
    .resp_rdy     (resp_rdy),
    .mul_req      (mul_req_if.steer),
    .div_req      (div_req_if.steer),
    .mul_result   (mul_result),
    .mul_resp_val (mul_resp_val),
    .div_result   (div_result),
    .div_resp_val (div_resp_val),
    .mul_resp_rdy (mul_resp_rdy),
    .div_resp_rdy (div_resp_rdy)
  );

  int_mul_iterative #(.N_ITER(N_ITER)) mul (
    .clk      (clk),
    .reset    (reset),
    .req      (mul_req_if.engine),
    .result   (mul_result),
    .resp_val (mul_resp_val),
    .resp_rdy (mul_resp_rdy)
  );

  // divider handshake goes to the FSM, payload to the datapath
  int_div_ctrl #(.N_ITER(N_ITER)) div_ctrl (
    .clk      (clk),
    .reset    (reset),
    .req_val  (div_req_if.val),
    .req_rdy  (div_req_if.rdy),
    .resp_val (div_resp_val),
    .resp_rdy (div_resp_rdy),
    .load_en  (div_load_en),
    .step_en  (div_step_en)
  );

  int_div_dpath div_dpath (
    .clk           (clk),
    .reset         (reset),
    .req_a         (div_req_if.a),
    .req_b         (div_req_if.b),
    .req_is_signed (div_req_if.is_signed),
    .load_en       (div_load_en),
    .step_en       (div_step_en),
    .result        (div_result)
  );

endmodule

// ==== verilog/int_div_dpath.sv ====
// restoring divider datapath on operand magnitudes
// divide by zero gives quotient all ones and remainder = dividend
// most negative / -1 gives quotient 0x80000000, remainder 0

`timescale 1ns/1ns

module int_div_dpath (
  input  logic                         clk,
  input  logic                         reset,
  input  logic [imuldiv_pkg::XLEN-1:0] req_a,
  input  logic [imuldiv_pkg::XLEN-1:0] req_b,
  input  logic                         req_is_signed,
  input  logic                         load_en,
  input  logic                         step_en,
  output imuldiv_pkg::muldiv_result_t  result
);

  localparam int W = imuldiv_pkg::XLEN;

  // {remainder (W+1 bits), quotient (W bits)}
  logic [2*W:0]   rem_quo;
  logic [W-1:0]   div_mag;
  logic [W-1:0]   orig_a;
  logic           q_neg;
  logic           r_neg;
  logic           div_zero;

  logic [W-1:0]   mag_a;
  logic [W-1:0]   mag_b;
  logic [2*W:0]   rq_shift;
  logic [W+1:0]   diff;
  logic           borrow;
  logic [W-1:0]   quo;
  logic [W-1:0]   rem;

  assign mag_a = (req_is_signed && req_a[W-1]) ? (~req_a + 1'b1) : req_a;
  assign mag_b = (req_is_signed && req_b[W-1]) ? (~req_b + 1'b1) : req_b;

  // --------------------
  // shift-subtract step
  // --------------------

  assign rq_shift = rem_quo << 1;
  // one extra bit so the borrow survives a 33-bit partial remainder
  assign diff     = {1'b0, rq_shift[2*W:W]} - {2'b0, div_mag};
  assign borrow   = diff[W+1];

  always_ff @(posedge clk) begin
    if (load_en) begin
      rem_quo <= {{(W+1){1'b0}}, mag_a};
      div_mag <= mag_b;
      orig_a  <= req_a;
    end else if (step_en) begin
      // borrow means restore, quotient bit is 0
      if (borrow) rem_quo <= {rq_shift[2*W:1], 1'b0};
      else rem_quo <= {diff[W:0], rq_shift[W-1:1], 1'b1};
    end
  end

  // sign and zero flags, cleared on reset
  always_ff @(posedge clk) begin
    if (reset) begin
      q_neg    <= 1'b0;
      r_neg    <= 1'b0;
      div_zero <= 1'b0;
    end else if (load_en) begin
      q_neg    <= req_is_signed && (req_a[W-1] ^ req_b[W-1]);
      // remainder follows the dividend sign
      r_neg    <= req_is_signed && req_a[W-1];
      div_zero <= (req_b == '0);
    end
  end

  // --------------------
  // result fix-up
  // --------------------

  assign quo = q_neg ? (~rem_quo[W-1:0] + 1'b1) : rem_quo[W-1:0];
  assign rem = r_neg ? (~rem_quo[2*W-1:W] + 1'b1) : rem_quo[2*W-1:W];

  always_comb begin
    if (div_zero) begin
      result.hi = orig_a;
      result.lo = '1;
    end else begin
      result.hi = rem;
      result.lo = quo;
    end
  end

endmodule

// ==== verilog/int_div_ctrl.sv ====
// divider control, IDLE -> CALC for N_ITER cycles -> DONE
// owns both divider handshakes, datapath only follows the enables

`timescale 1ns/1ns

module int_div_ctrl #(
  parameter int N_ITER = 32
) (
  input  logic clk,
  input  logic reset,
  input  logic req_val,
  output logic req_rdy,
  output logic resp_val,
  input  logic resp_rdy,
  output logic load_en,
  output logic step_en
);

  localparam int CNT_W = imuldiv_pkg::ITER_CNT_W;

  typedef enum logic [1:0] {
    IDLE = 2'd0,
    CALC = 2'd1,
    DONE = 2'd2
  } div_state_e;

  div_state_e       state;
  div_state_e       state_next;
  logic [CNT_W-1:0] cnt;
  logic             last_step;

  assign last_step = (cnt == CNT_W'(N_ITER - 1));

  // --------------------
  // next state
  // --------------------

  always_comb begin
    state_next = state;
    case (state)
      IDLE: if (req_val) state_next = CALC;
      CALC: if (last_step) state_next = DONE;
      // leave only once the response has been taken
      DONE: if (resp_rdy) state_next = IDLE;
      default: state_next = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  // step counter, cleared on entry to CALC
  always_ff @(posedge clk) begin
    if (reset) begin
      cnt <= '0;
    end else if (state == IDLE) begin
      cnt <= '0;
    end else if (state == CALC && !last_step) begin
      cnt <= cnt + 1'b1;
    end
  end

  // --------------------
  // outputs
  // --------------------

  assign req_rdy  = (state == IDLE);
  assign resp_val = (state == DONE);

  // load on the request transfer edge
  assign load_en  = req_val && (state == IDLE);

  // one shift-subtract per CALC cycle
  assign step_en  = (state == CALC);

endmodule

// ==== verilog/int_mul_iterative.sv ====
// shift-add multiplier, one partial product per cycle for N_ITER cycles
// works on magnitudes, full 64-bit product, sign applied at the output

`timescale 1ns/1ns

module int_mul_iterative #(
  parameter int N_ITER = 32
) (
  input  logic                        clk,
  input  logic                        reset,
  muldiv_req_if.engine                req,
  output imuldiv_pkg::muldiv_result_t result,
  output logic                        resp_val,
  input  logic                        resp_rdy
);

  localparam int W     = imuldiv_pkg::XLEN;
  localparam int CNT_W = imuldiv_pkg::ITER_CNT_W;

  typedef enum logic [1:0] {
    IDLE = 2'd0,
    CALC = 2'd1,
    DONE = 2'd2
  } mul_state_e;

  mul_state_e         state;
  logic [CNT_W-1:0]   cnt;

  // datapath registers
  logic [2*W-1:0]     mcand;
  logic [W-1:0]       mplier;
  logic [2*W-1:0]     acc;
  logic               neg;

  logic [W-1:0]       mag_a;
  logic [W-1:0]       mag_b;
  logic               load;

  // magnitudes of the incoming operands
  assign mag_a = (req.is_signed && req.a[W-1]) ? (~req.a + 1'b1) : req.a;
  assign mag_b = (req.is_signed && req.b[W-1]) ? (~req.b + 1'b1) : req.b;

  assign req.rdy  = (state == IDLE);
  assign resp_val = (state == DONE);
  assign load     = req.val && (state == IDLE);

  // --------------------
  // control
  // --------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        IDLE: if (load) begin
          state <= CALC;
          cnt   <= '0;
        end
        CALC: if (cnt == CNT_W'(N_ITER - 1)) state <= DONE;
              else cnt <= cnt + 1'b1;
        DONE: if (resp_rdy) state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  // --------------------
  // datapath
  // --------------------

  always_ff @(posedge clk) begin
    if (load) begin
      mcand  <= {{W{1'b0}}, mag_a};
      mplier <= mag_b;
      acc    <= '0;
      neg    <= req.is_signed && (req.a[W-1] ^ req.b[W-1]);
    end else if (state == CALC) begin
      // add the shifted multiplicand under the low multiplier bit
      if (mplier[0]) acc <= acc + mcand;
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  // registers are frozen outside CALC, so this holds through back-pressure
  assign result = neg ? (~acc + 1'b1) : acc;

endmodule

// ==== verilog/muldiv_steer.sv ====
// routes one request at a time to the multiplier or the divider
// a new request is held off until the previous response is taken

`timescale 1ns/1ns

module muldiv_steer (
  input  logic                        clk,
  input  logic                        reset,
  input  imuldiv_pkg::muldiv_op_e     req_op,
  input  logic [31:0]                 req_a,
  input  logic [31:0]                 req_b,
  input  logic                        req_val,
  output logic                        req_rdy,
  output imuldiv_pkg::muldiv_result_t resp_result,
  output logic                        resp_val,
  input  logic                        resp_rdy,
  muldiv_req_if.steer                 mul_req,
  muldiv_req_if.steer                 div_req,
  input  imuldiv_pkg::muldiv_result_t mul_result,
  input  logic                        mul_resp_val,
  input  imuldiv_pkg::muldiv_result_t div_result,
  input  logic                        div_resp_val,
  output logic                        mul_resp_rdy,
  output logic                        div_resp_rdy
);

  logic busy;
  // recorded engine of the operation in flight, 1 = divider
  logic sel_div;
  logic is_div;
  logic is_signed;

  // --------------------
  // opcode decode
  // --------------------

  always_comb begin
    is_div    = 1'b0;
    is_signed = 1'b0;
    unique case (req_op)
      imuldiv_pkg::OP_MUL:  is_signed = 1'b1;
      imuldiv_pkg::OP_MULU: is_signed = 1'b0;
      imuldiv_pkg::OP_DIV: begin
        is_div    = 1'b1;
        is_signed = 1'b1;
      end
      imuldiv_pkg::OP_DIVU: is_div = 1'b1;
      default: is_div = 1'b0;
    endcase
  end

  // payload goes to both engines, only the chosen one sees val
  assign mul_req.is_signed = is_signed;
  assign mul_req.a         = req_a;
  assign mul_req.b         = req_b;
  assign mul_req.val       = req_val && !busy && !is_div;

  assign div_req.is_signed = is_signed;
  assign div_req.a         = req_a;
  assign div_req.b         = req_b;
  assign div_req.val       = req_val && !busy && is_div;

  // ready only when idle and the target engine can take it
  assign req_rdy = !busy && (is_div ? div_req.rdy : mul_req.rdy);

  // --------------------
  // busy flag and engine select
  // --------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      busy    <= 1'b0;
      sel_div <= 1'b0;
    end else if (req_val && req_rdy) begin
      busy    <= 1'b1;
      sel_div <= is_div;
    end else if (resp_val && resp_rdy) begin
      busy <= 1'b0;
    end
  end

  // response comes back from the recorded engine only
  assign resp_result  = sel_div ? div_result : mul_result;
  assign resp_val     = sel_div ? div_resp_val : mul_resp_val;
  assign mul_resp_rdy = resp_rdy && !sel_div;
  assign div_resp_rdy = resp_rdy && sel_div;

endmodule

// ==== verilog/muldiv_req_if.sv ====
// request bundle from the steering block to one engine
// payload must stay steady while val is high and rdy is low

`timescale 1ns/1ns

interface muldiv_req_if;

  // operands are treated as two's complement when set
  logic                          is_signed;
  logic [imuldiv_pkg::XLEN-1:0]  a;
  logic [imuldiv_pkg::XLEN-1:0]  b;

  // valid/ready pair, transfer when both are high on a rising edge
  logic                          val;
  logic                          rdy;

  // steering side drives the request
  modport steer (
    output is_signed, a, b, val,
    input  rdy
  );

  // engine side consumes it and answers with rdy
  modport engine (
    input  is_signed, a, b, val,
    output rdy
  );

endinterface

// ==== verilog/imuldiv_pkg.sv ====
// shared types and sizes for the multiply/divide unit
// result layout is {hi, lo}: product words, or remainder and quotient

package imuldiv_pkg;

  // operand width of the core
  localparam int XLEN = 32;

  // iteration counter width, holds any step count up to 63
  localparam int ITER_CNT_W = 6;

  // --------------------
  // operation codes
  // --------------------

  typedef enum logic [1:0] {
    OP_MUL  = 2'd0,
    OP_MULU = 2'd1,
    OP_DIV  = 2'd2,
    OP_DIVU = 2'd3
  } muldiv_op_e;

  // --------------------
  // result word
  // --------------------

  // multiply: hi = upper product word, lo = lower product word
  // divide:   hi = remainder,          lo = quotient
  typedef struct packed {
    logic [XLEN-1:0] hi;
    logic [XLEN-1:0] lo;
  } muldiv_result_t;

endpackage
